/* hdl/triadic_alu_pkg.sv */
`default_nettype none

package triadic_alu_pkg;

    // Forward path latency in clock cycles
    localparam int PIPELINE_STAGES = 4;

    // --------------------
    // Field types

    // Truth table of a two-input function, indexed by {a, b}
    typedef logic [3:0] dyadic_op_t;
    // Source of the R-like steering operand
    typedef logic [1:0] r_sel_t;
    // Shift applied after the final combine
    typedef logic [1:0] shift_sel_t;
    // Operand negation, one bit per operand
    typedef logic [1:0] add_sub_t;

    // Full control word
    localparam int CTRL_WIDTH = 20;
    typedef logic [CTRL_WIDTH-1:0] ctrl_t;

    // --------------------
    // Lowest bit of each field, MSB field last
    localparam int R_SEL_LSB   = 0;
    localparam int D1_LSB      = 2;
    localparam int D2_LSB      = 6;
    localparam int DUAL_LSB    = 10;
    localparam int ADD_SUB_LSB = 11;
    localparam int D3_LSB      = 13;
    localparam int SHIFT_LSB   = 17;
    localparam int SPLIT_LSB   = 19;

    // --------------------
    // Field encodings
    localparam r_sel_t R_SEL_R        = 2'd0;
    localparam r_sel_t R_SEL_ZERO     = 2'd1;
    localparam r_sel_t R_SEL_NEGATIVE = 2'd2;
    localparam r_sel_t R_SEL_S        = 2'd3;

    localparam shift_sel_t SHIFT_NONE = 2'd0;
    localparam shift_sel_t SHIFT_LSR  = 2'd1;
    localparam shift_sel_t SHIFT_ASR  = 2'd2;
    localparam shift_sel_t SHIFT_LSL  = 2'd3;

    // Bit positions inside add_sub_t
    localparam int NEG_A_BIT = 0;
    localparam int NEG_B_BIT = 1;

endpackage

`default_nettype wire

/* hdl/dyadic_boolean_op.sv */
`timescale 1ns/1ps
`default_nettype none

// Universal two-input bitwise Boolean operator
// Any of the sixteen dyadic functions, chosen by its truth table
module dyadic_boolean_op #(
    parameter int WORD_WIDTH = 32
) (
    input  wire triadic_alu_pkg::dyadic_op_t op,
    input  wire [WORD_WIDTH-1:0]             a,
    input  wire [WORD_WIDTH-1:0]             b,
    output logic [WORD_WIDTH-1:0]            o
);

    // --------------------
    // One truth-table lookup per bit

    genvar i;

    generate
        for (i = 0; i < WORD_WIDTH; i++) begin : g_bit
            // Index is 2*a + b
            // e.g. 4'b1000 is AND, 4'b1110 is OR, 4'b1010 passes b
            assign o[i] = op[{a[i], b[i]}];
        end
    endgenerate

endmodule

`default_nettype wire

/* hdl/signed_add_sub.sv */
`timescale 1ns/1ps
`default_nettype none

// Computes +/-A +/-B modulo 2^WORD_WIDTH
// Carry and signed overflow come from the final addition
module signed_add_sub #(
    parameter int WORD_WIDTH = 32
) (
    input  wire [WORD_WIDTH-1:0]           a,
    input  wire [WORD_WIDTH-1:0]           b,
    input  wire triadic_alu_pkg::add_sub_t add_sub,
    output logic [WORD_WIDTH-1:0]          sum,
    output logic                           carry_out,
    output logic                           overflow
);

    import triadic_alu_pkg::*;

    // Operands after optional negation
    logic [WORD_WIDTH-1:0] op_a;
    logic [WORD_WIDTH-1:0] op_b;

    // --------------------
    // Two's complement negation wraps, so -MIN stays MIN
    assign op_a = add_sub[NEG_A_BIT] ? (~a + 1'b1) : a;
    assign op_b = add_sub[NEG_B_BIT] ? (~b + 1'b1) : b;

    // --------------------
    // One extra bit catches the carry beyond the MSB
    assign {carry_out, sum} = {1'b0, op_a} + {1'b0, op_b};

    // --------------------
    // Same input signs, different result sign
    assign overflow = (op_a[WORD_WIDTH-1] == op_b[WORD_WIDTH-1])
                   && (sum[WORD_WIDTH-1] != op_a[WORD_WIDTH-1]);

endmodule

`default_nettype wire

/* hdl/delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

// Shift-register delay, DEPTH cycles, cleared by reset
// DEPTH of 0 is a plain connection
module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  wire              clock,
    input  wire              rst_n,
    input  wire [WIDTH-1:0]  in,
    output logic [WIDTH-1:0] out
);

    generate
        if (DEPTH == 0) begin : g_pass
            // No registers at all
            assign out = in;
        end else begin : g_chain
            // Stage 0 is nearest the input
            logic [WIDTH-1:0] stage [DEPTH];

            always_ff @(posedge clock) begin
                if (!rst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= in;
                    // Move everything one step on
                    for (int i = 1; i < DEPTH; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end

            // Oldest entry leaves
            assign out = stage[DEPTH-1];
        end
    endgenerate

endmodule

`default_nettype wire

/* hdl/triadic_forward_path.sv */
`timescale 1ns/1ps
`default_nettype none

// Four-stage triadic Boolean / arithmetic datapath
// Ra = g(A,B,R) when split, Rb = shift(h(g'(A,B,R), +/-A+/-B))
module triadic_forward_path #(
    parameter int WORD_WIDTH = 32
) (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire                         in_valid,
    input  wire triadic_alu_pkg::ctrl_t control,
    input  wire [WORD_WIDTH-1:0]        a,
    input  wire [WORD_WIDTH-1:0]        b,
    input  wire [WORD_WIDTH-1:0]        r,
    input  wire [WORD_WIDTH-1:0]        s,
    input  wire                         r_zero,
    input  wire                         r_negative,
    output logic [WORD_WIDTH-1:0]       ra,
    output logic [WORD_WIDTH-1:0]       rb,
    output logic                        carry_out,
    output logic                        overflow,
    output logic                        out_valid
);

    import triadic_alu_pkg::*;

    // Sum leaves the adder and is consumed two stages later
    localparam int SUM_DELAY = 2;

    // Control word as seen by each stage
    ctrl_t ctrl_pipe [PIPELINE_STAGES];
    // Control fields, each taken at the stage that uses it
    r_sel_t     r_sel;
    dyadic_op_t d1_op;
    dyadic_op_t d2_op;
    dyadic_op_t d3_op;
    add_sub_t   add_sub;
    logic       dual;
    shift_sel_t shift_sel;
    logic       split;
    // Stage 0
    logic [WORD_WIDTH-1:0] r_operand;
    logic [WORD_WIDTH-1:0] d1_raw;
    logic [WORD_WIDTH-1:0] d2_raw;
    logic [WORD_WIDTH-1:0] sum_raw;
    logic                  carry_raw;
    logic                  overflow_raw;
    logic [WORD_WIDTH-1:0] r_operand_q;
    logic [WORD_WIDTH-1:0] d1_q;
    logic [WORD_WIDTH-1:0] d2_q;
    logic [1:0]            pred_q;
    // Stage 1
    logic [WORD_WIDTH-1:0] r_steer;
    logic [WORD_WIDTH-1:0] triadic_q;
    logic [WORD_WIDTH-1:0] steered_q;
    // Stage 2
    logic [WORD_WIDTH-1:0] sum_q;
    logic [WORD_WIDTH-1:0] d3_raw;
    logic [WORD_WIDTH-1:0] d3_q;
    logic [WORD_WIDTH-1:0] triadic_d;
    // Stage 3
    logic [WORD_WIDTH-1:0] shifted;

    // Per-bit pick, mask bit 1 takes the d2 side
    function automatic logic [WORD_WIDTH-1:0] bit_select(
        input logic [WORD_WIDTH-1:0] mask,
        input logic [WORD_WIDTH-1:0] when_0,
        input logic [WORD_WIDTH-1:0] when_1
    );
        return (mask & when_1) | (~mask & when_0);
    endfunction

    // --------------------
    // Control pipeline, one register per stage boundary

    assign ctrl_pipe[0] = control;

    genvar k;

    generate
        for (k = 1; k < PIPELINE_STAGES; k++) begin : g_ctrl
            delay_line #(
                .DEPTH (1),
                .WIDTH (CTRL_WIDTH)
            ) u_ctrl_delay (
                .clock (clock),
                .rst_n (rst_n),
                .in    (ctrl_pipe[k-1]),
                .out   (ctrl_pipe[k])
            );
        end
    endgenerate

    assign r_sel     = ctrl_pipe[0][R_SEL_LSB +: $bits(r_sel_t)];
    assign d1_op     = ctrl_pipe[0][D1_LSB +: $bits(dyadic_op_t)];
    assign d2_op     = ctrl_pipe[0][D2_LSB +: $bits(dyadic_op_t)];
    assign add_sub   = ctrl_pipe[0][ADD_SUB_LSB +: $bits(add_sub_t)];
    assign dual      = ctrl_pipe[1][DUAL_LSB];
    assign d3_op     = ctrl_pipe[2][D3_LSB +: $bits(dyadic_op_t)];
    assign shift_sel = ctrl_pipe[3][SHIFT_LSB +: $bits(shift_sel_t)];
    assign split     = ctrl_pipe[3][SPLIT_LSB];

    // Valid bit follows the operation through every stage
    delay_line #(
        .DEPTH (PIPELINE_STAGES),
        .WIDTH (1)
    ) u_valid_delay (
        .clock (clock),
        .rst_n (rst_n),
        .in    (in_valid),
        .out   (out_valid)
    );

    // --------------------
    // Stage 0: pick R, d1 and d2, start add/sub

    // Flags replicated into full-width masks
    always_comb begin
        case (r_sel)
            R_SEL_R:        r_operand = r;
            R_SEL_ZERO:     r_operand = {WORD_WIDTH{r_zero}};
            R_SEL_NEGATIVE: r_operand = {WORD_WIDTH{r_negative}};
            R_SEL_S:        r_operand = s;
        endcase
    end

    dyadic_boolean_op #(.WORD_WIDTH(WORD_WIDTH)) d1 (.op(d1_op), .a(a), .b(b), .o(d1_raw));
    dyadic_boolean_op #(.WORD_WIDTH(WORD_WIDTH)) d2 (.op(d2_op), .a(a), .b(b), .o(d2_raw));

    signed_add_sub #(
        .WORD_WIDTH (WORD_WIDTH)
    ) u_add_sub (
        .a         (a),
        .b         (b),
        .add_sub   (add_sub),
        .sum       (sum_raw),
        .carry_out (carry_raw),
        .overflow  (overflow_raw)
    );

    // Adder registers sit behind it, retiming can spread them
    delay_line #(
        .DEPTH (SUM_DELAY),
        .WIDTH (WORD_WIDTH)
    ) u_sum_delay (
        .clock (clock),
        .rst_n (rst_n),
        .in    (sum_raw),
        .out   (sum_q)
    );

    // Predicates ride straight to the outputs
    delay_line #(
        .DEPTH (PIPELINE_STAGES),
        .WIDTH (2)
    ) u_pred_delay (
        .clock (clock),
        .rst_n (rst_n),
        .in    ({carry_raw, overflow_raw}),
        .out   (pred_q)
    );

    assign carry_out = pred_q[1];
    assign overflow  = pred_q[0];

    // --------------------
    // Stages 0 to 2 registers

    // Dual mode steers the second pick with the complement
    assign r_steer = dual ? ~r_operand_q : r_operand_q;

    // Stage 2 combine, second pick against the sum
    dyadic_boolean_op #(.WORD_WIDTH(WORD_WIDTH)) d3 (.op(d3_op), .a(steered_q), .b(sum_q),
        .o(d3_raw));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            r_operand_q <= '0;
            d1_q        <= '0;
            d2_q        <= '0;
            triadic_q   <= '0;
            steered_q   <= '0;
            d3_q        <= '0;
            triadic_d   <= '0;
        end else begin
            r_operand_q <= r_operand;
            d1_q        <= d1_raw;
            d2_q        <= d2_raw;
            // Stage 1, plain triadic result and its steered twin
            triadic_q   <= bit_select(r_operand_q, d1_q, d2_q);
            steered_q   <= bit_select(r_steer, d1_q, d2_q);
            // Stage 2, triadic result just waits a stage
            d3_q        <= d3_raw;
            triadic_d   <= triadic_q;
        end
    end

    // --------------------
    // Stage 3: shift, then split

    always_comb begin
        case (shift_sel)
            SHIFT_NONE: shifted = d3_q;
            SHIFT_LSR:  shifted = d3_q >> 1;
            SHIFT_ASR:  shifted = $signed(d3_q) >>> 1;
            SHIFT_LSL:  shifted = d3_q << 1;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ra <= '0;
            rb <= '0;
        end else begin
            rb <= shifted;
            // Split hands Ra the bare triadic result
            ra <= split ? triadic_d : shifted;
        end
    end

endmodule

`default_nettype wire

/* hdl/result_feedback.sv */
`timescale 1ns/1ps
`default_nettype none

// Holds R (last valid Ra) and the persistent S
// Zero and negative flags derived from R
module result_feedback #(
    parameter int WORD_WIDTH = 32
) (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire [WORD_WIDTH-1:0]  ra,
    input  wire                   ra_valid,
    input  wire                   s_load,
    input  wire [WORD_WIDTH-1:0]  s_value,
    output logic [WORD_WIDTH-1:0] r,
    output logic [WORD_WIDTH-1:0] s,
    output logic                  r_zero,
    output logic                  r_negative
);

    // --------------------
    // R register, one cycle behind a valid Ra

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            r <= '0;
        end else if (ra_valid) begin
            r <= ra;
        end
    end

    // --------------------
    // S register, only changed on request

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s <= '0;
        end else if (s_load) begin
            s <= s_value;
        end
    end

    // --------------------
    // Flags track R with no extra delay

    assign r_zero     = (r == '0);
    // Sign bit of R
    assign r_negative = r[WORD_WIDTH-1];

endmodule

`default_nettype wire

/* hdl/triadic_alu.sv */
`timescale 1ns/1ps
`default_nettype none

// Triadic ALU top, forward path plus R/S feedback
module triadic_alu #(
    parameter int WORD_WIDTH = 32
) (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire                         in_valid,
    input  wire triadic_alu_pkg::ctrl_t control,
    input  wire [WORD_WIDTH-1:0]        a,
    input  wire [WORD_WIDTH-1:0]        b,
    input  wire                         s_load,
    input  wire [WORD_WIDTH-1:0]        s_value,
    output logic [WORD_WIDTH-1:0]       ra,
    output logic [WORD_WIDTH-1:0]       rb,
    output logic                        carry_out,
    output logic                        overflow,
    output logic                        out_valid
);

    // Feedback operands into the forward path
    logic [WORD_WIDTH-1:0] r;
    logic [WORD_WIDTH-1:0] s;
    logic                  r_zero;
    logic                  r_negative;

    // --------------------
    // Datapath

    triadic_forward_path #(
        .WORD_WIDTH (WORD_WIDTH)
    ) u_forward_path (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .control    (control),
        .a          (a),
        .b          (b),
        .r          (r),
        .s          (s),
        .r_zero     (r_zero),
        .r_negative (r_negative),
        .ra         (ra),
        .rb         (rb),
        .carry_out  (carry_out),
        .overflow   (overflow),
        .out_valid  (out_valid)
    );

    // --------------------
    // Ra loops back as R

    result_feedback #(
        .WORD_WIDTH (WORD_WIDTH)
    ) u_feedback (
        .clock      (clock),
        .rst_n      (rst_n),
        .ra         (ra),
        .ra_valid   (out_valid),
        .s_load     (s_load),
        .s_value    (s_value),
        .r          (r),
        .s          (s),
        .r_zero     (r_zero),
        .r_negative (r_negative)
    );

endmodule

`default_nettype wire

/* tb/tb_triadic_alu.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for the triadic ALU
// Random and directed operations checked against a model of the datapath rules
module tb_triadic_alu;

    import triadic_alu_pkg::*;

    localparam int WORD_WIDTH = 32;
    // Longest any single wait may take, in cycles
    localparam int WAIT_LIMIT = 64;

    typedef logic [WORD_WIDTH-1:0] word_t;

    // Expected outputs of one operation
    typedef struct packed {
        word_t ra;
        word_t rb;
        logic  carry;
        logic  overflow;
    } result_t;

    logic  clock;
    logic  rst_n;
    logic  in_valid;
    ctrl_t control;
    word_t a;
    word_t b;
    logic  s_load;
    word_t s_value;
    word_t ra;
    word_t rb;
    logic  carry_out;
    logic  overflow;
    logic  out_valid;

    // Model copies of R and S
    word_t       model_r;
    word_t       model_s;
    // Expectations in issue order
    result_t     expected_q [$];
    logic [31:0] lcg_state;

    triadic_alu #(
        .WORD_WIDTH (WORD_WIDTH)
    ) i_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .control   (control),
        .a         (a),
        .b         (b),
        .s_load    (s_load),
        .s_value   (s_value),
        .ra        (ra),
        .rb        (rb),
        .carry_out (carry_out),
        .overflow  (overflow),
        .out_valid (out_valid)
    );

    // 100 ns period
    always #50 clock = ~clock;

    // --------------------
    // Random numbers

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper halves only, the low LCG bits repeat quickly
    function automatic word_t random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[31:16], lo[31:16]};
    endfunction

    // --------------------
    // Reference model

    // Sum of the minterms enabled in the truth table
    function automatic word_t dyadic_apply(input dyadic_op_t op, input word_t x, input word_t y);
        return ({WORD_WIDTH{op[3]}} & x & y)
             | ({WORD_WIDTH{op[2]}} & x & ~y)
             | ({WORD_WIDTH{op[1]}} & ~x & y)
             | ({WORD_WIDTH{op[0]}} & ~x & ~y);
    endfunction

    function automatic result_t compute_expected(
        input ctrl_t ctrl,
        input word_t a_in,
        input word_t b_in,
        input word_t r_in,
        input word_t s_in,
        input logic  zero_flag,
        input logic  negative_flag
    );
        result_t             res;
        r_sel_t              sel;
        word_t               r_operand;
        word_t               d1_val;
        word_t               d2_val;
        word_t               triadic;
        word_t               triadic_dual;
        word_t               op_a;
        word_t               op_b;
        logic [WORD_WIDTH:0] wide_sum;
        word_t               combined;
        word_t               shifted;

        sel = ctrl[R_SEL_LSB +: 2];
        case (sel)
            R_SEL_R:        r_operand = r_in;
            R_SEL_ZERO:     r_operand = {WORD_WIDTH{zero_flag}};
            R_SEL_NEGATIVE: r_operand = {WORD_WIDTH{negative_flag}};
            default:        r_operand = s_in;
        endcase

        // R bit 1 picks d2, R bit 0 picks d1
        d1_val       = dyadic_apply(ctrl[D1_LSB +: 4], a_in, b_in);
        d2_val       = dyadic_apply(ctrl[D2_LSB +: 4], a_in, b_in);
        triadic      = (r_operand & d2_val) | (~r_operand & d1_val);
        triadic_dual = ctrl[DUAL_LSB] ? ((~r_operand & d2_val) | (r_operand & d1_val)) : triadic;

        // Plus or minus each operand, modulo the word
        op_a     = ctrl[ADD_SUB_LSB + NEG_A_BIT] ? -a_in : a_in;
        op_b     = ctrl[ADD_SUB_LSB + NEG_B_BIT] ? -b_in : b_in;
        wide_sum = {1'b0, op_a} + {1'b0, op_b};

        res.carry    = wide_sum[WORD_WIDTH];
        res.overflow = (op_a[WORD_WIDTH-1] == op_b[WORD_WIDTH-1])
                    && (wide_sum[WORD_WIDTH-1] != op_a[WORD_WIDTH-1]);

        combined = dyadic_apply(ctrl[D3_LSB +: 4], triadic_dual, wide_sum[WORD_WIDTH-1:0]);
        case (shift_sel_t'(ctrl[SHIFT_LSB +: 2]))
            SHIFT_LSR: shifted = {1'b0, combined[WORD_WIDTH-1:1]};
            SHIFT_ASR: shifted = {combined[WORD_WIDTH-1], combined[WORD_WIDTH-1:1]};
            SHIFT_LSL: shifted = {combined[WORD_WIDTH-2:0], 1'b0};
            default:   shifted = combined;
        endcase

        res.rb = shifted;
        res.ra = ctrl[SPLIT_LSB] ? triadic : shifted;
        return res;
    endfunction

    // --------------------
    // Control word helpers

    function automatic ctrl_t make_ctrl(
        input logic       split,
        input shift_sel_t shift,
        input dyadic_op_t d3,
        input add_sub_t   negate,
        input logic       dual,
        input dyadic_op_t d2,
        input dyadic_op_t d1,
        input r_sel_t     sel
    );
        ctrl_t c;
        c                    = '0;
        c[SPLIT_LSB]         = split;
        c[SHIFT_LSB +: 2]    = shift;
        c[D3_LSB +: 4]       = d3;
        c[ADD_SUB_LSB +: 2]  = negate;
        c[DUAL_LSB]          = dual;
        c[D2_LSB +: 4]       = d2;
        c[D1_LSB +: 4]       = d1;
        c[R_SEL_LSB +: 2]    = sel;
        return c;
    endfunction

    // Random operators and negation, fixed steering fields
    function automatic ctrl_t random_ctrl(input logic split, input shift_sel_t shift,
        input logic dual, input r_sel_t sel);
        logic [31:0] bits;
        bits = next_random();
        return make_ctrl(split, shift, bits[27:24], bits[21:20], dual, bits[19:16],
            bits[31:28], sel);
    endfunction

    // --------------------
    // Checking

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("ERR time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Verification failed");
        $fatal(1, "Wait limit exceeded");
    endtask

    // Pops one expectation per valid result, R follows each Ra
    always @(negedge clock) begin : compare_outputs
        result_t exp_res;
        if (rst_n && out_valid) begin
            if (expected_q.size() == 0) begin
                $display("At %0t out_valid was high with no operation outstanding", $time);
                $display("Verification failed");
                $fatal(1, "Unexpected result");
            end else begin
                exp_res = expected_q.pop_front();
                check_value("ra", ra, exp_res.ra);
                check_value("rb", rb, exp_res.rb);
                check_value("carry_out", WORD_WIDTH'(carry_out), WORD_WIDTH'(exp_res.carry));
                check_value("overflow", WORD_WIDTH'(overflow), WORD_WIDTH'(exp_res.overflow));
                model_r = exp_res.ra;
            end
        end
    end

    // --------------------
    // Stimulus tasks, all entered on a falling edge

    task automatic issue_op(input ctrl_t ctrl, input word_t a_in, input word_t b_in);
        in_valid = 1'b1;
        control  = ctrl;
        a        = a_in;
        b        = b_in;
        expected_q.push_back(compute_expected(ctrl, a_in, b_in, model_r, model_s,
            model_r == '0, model_r[WORD_WIDTH-1]));
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic load_s(input word_t value);
        s_load  = 1'b1;
        s_value = value;
        @(negedge clock);
        s_load  = 1'b0;
        model_s = value;
    endtask

    // Empty pipeline, then one more edge so R has taken the last Ra
    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            @(posedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout("the pipeline to drain");
            end
        end
        @(negedge clock);
    endtask

    // Sum of value and zero, passed straight to Ra
    task automatic set_r(input word_t value);
        issue_op(make_ctrl(1'b0, SHIFT_NONE, 4'b1010, 2'b00, 1'b0, 4'b0110, 4'b1000, R_SEL_S),
            value, '0);
        wait_drained();
    endtask

    // --------------------
    // Test sequence

    initial begin : run_tests
        word_t edge_values [5];
        word_t targets [3];
        word_t x;
        word_t y;
        int    cycles;

        lcg_state     = 32'h38b4;
        clock         = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        control       = '0;
        a             = '0;
        b             = '0;
        s_load        = 1'b0;
        s_value       = '0;
        model_r       = '0;
        model_s       = '0;
        edge_values   = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
                          32'h0000_0001};
        targets       = '{32'h0000_0000, 32'h8000_1234, 32'h0000_5a5a};

        repeat (2) @(negedge clock);
        rst_n = 1'b1;

        // Quiet outputs after reset
        check_value("ra", ra, '0);
        check_value("rb", rb, '0);
        repeat (6) begin
            check_value("out_valid", WORD_WIDTH'(out_valid), '0);
            @(negedge clock);
        end

        // Latency of the first operation
        x = random_word();
        y = random_word();
        issue_op(random_ctrl(1'b0, SHIFT_NONE, 1'b0, R_SEL_S), x, y);
        cycles = 1;
        while (out_valid !== 1'b1) begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout("the first out_valid");
            end
        end
        check_value("latency", WORD_WIDTH'(cycles), WORD_WIDTH'(PIPELINE_STAGES));
        wait_drained();

        // Triadic Boolean stream steered by S
        load_s(random_word());
        for (int i = 0; i < 64; i++) begin
            x = random_word();
            y = random_word();
            issue_op(random_ctrl(1'b1, SHIFT_NONE, 1'b0, R_SEL_S), x, y);
        end
        wait_drained();

        // Add/sub predicates, d3 passes the sum
        for (int neg = 0; neg < 4; neg++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue_op(make_ctrl(1'b0, SHIFT_NONE, 4'b1010, add_sub_t'(neg), 1'b0,
                        4'b0110, 4'b1000, R_SEL_S), edge_values[i], edge_values[j]);
                end
            end
            repeat (8) begin
                x = random_word();
                y = random_word();
                issue_op(make_ctrl(1'b0, SHIFT_NONE, 4'b1010, add_sub_t'(neg), 1'b0,
                    4'b0110, 4'b1000, R_SEL_S), x, y);
            end
        end
        wait_drained();

        // R, zero mask and negative mask after zero, negative and positive results
        for (int t = 0; t < 3; t++) begin
            for (int sel = 0; sel < 3; sel++) begin
                set_r(targets[t]);
                x = random_word();
                y = random_word();
                issue_op(make_ctrl(1'b1, SHIFT_NONE, 4'b1010, 2'b00, 1'b0, 4'b1010, 4'b1100,
                    r_sel_t'(sel)), x, y);
                wait_drained();
            end
        end

        // Dual steering through every shift
        load_s(random_word());
        for (int i = 0; i < 32; i++) begin
            x = random_word();
            y = random_word();
            issue_op(random_ctrl(1'b1, shift_sel_t'(i % 4), 1'b1, R_SEL_S), x, y);
        end
        wait_drained();

        // S loaded alongside one operation, used by the next
        for (int i = 0; i < 8; i++) begin
            s_load  = 1'b1;
            s_value = random_word();
            x = random_word();
            y = random_word();
            // Same edge as the load, still sees the old S
            issue_op(random_ctrl(1'b1, SHIFT_NONE, 1'b0, R_SEL_S), x, y);
            s_load  = 1'b0;
            model_s = s_value;
            x = random_word();
            y = random_word();
            issue_op(random_ctrl(1'b0, shift_sel_t'(i % 4), 1'b0, R_SEL_S), x, y);
        end
        wait_drained();

        // No stray results once the pipeline is empty
        repeat (PIPELINE_STAGES + 2) begin
            check_value("out_valid", WORD_WIDTH'(out_valid), '0);
            @(negedge clock);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* triadic_alu.f */
hdl/triadic_alu_pkg.sv
hdl/dyadic_boolean_op.sv
hdl/signed_add_sub.sv
hdl/delay_line.sv
hdl/triadic_forward_path.sv
hdl/result_feedback.sv
hdl/triadic_alu.sv
tb/tb_triadic_alu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the triadic ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f triadic_alu.f \
    --top-module tb_triadic_alu -o tb_triadic_alu

# The log decides the outcome, not the exit status
./obj_dir/tb_triadic_alu > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
